/* hdl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and register file
`define CPU_XLEN 32
`define CPU_NREG 16

// memory depths in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256
`define CPU_IMEM_AW $clog2(`CPU_IMEM_DEPTH)
`define CPU_DMEM_AW $clog2(`CPU_DMEM_DEPTH)

// host byte address map
`define CPU_AXI_AW 16
`define CPU_IMEM_BASE 16'h0000
`define CPU_DMEM_BASE 16'h1000
`define CPU_CTRL_ADDR 16'h2000 // bit 0 starts the core
`define CPU_STAT_ADDR 16'h2004 // bit 0 busy, bit 1 halted, bit 2 illegal
`define CPU_REG_BASE  16'h3000 // one register per word

// AXI response codes
`define CPU_RESP_OKAY   2'b00
`define CPU_RESP_SLVERR 2'b10
`define CPU_RESP_DECERR 2'b11

`endif

/* hdl/cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [31:0] instr_t; // imm | rs2 | rs1 | rd | opt | opcode

  typedef logic [$clog2(`CPU_NREG)-1:0] reg_idx_t;

  typedef enum logic [3:0] {
    OP_ADDI = 4'h0,
    OP_ALU  = 4'h1,
    OP_LW   = 4'h4,
    OP_SW   = 4'h5,
    OP_BEQ  = 4'h6,
    OP_HALT = 4'hA
  } opcode_e;

  // values 0 to 4 are the opt field of an alu instruction
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_PASS = 4'h8  // rs1 plus imm for addi, lw and sw
  } alu_op_e;

endpackage

`default_nettype wire

/* hdl/fetch_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module fetch_decode (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  output logic [`CPU_IMEM_AW-1:0] imem_addr,
  input  cpu_pkg::instr_t         imem_rdata,
  input  logic                    branch_taken,
  output logic                    exec_valid,
  output cpu_pkg::reg_idx_t       rd,
  output cpu_pkg::reg_idx_t       rs1,
  output cpu_pkg::reg_idx_t       rs2,
  output cpu_pkg::word_t          imm,
  output cpu_pkg::opcode_e        opcode,
  output cpu_pkg::alu_op_e        alu_op,
  output logic                    busy,
  output logic                    halted,
  output logic                    illegal
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_EXEC} state_e;

  state_e                  state;
  logic [`CPU_IMEM_AW-1:0] pc;
  logic [`CPU_IMEM_AW-1:0] pc_next;
  logic [3:0]              opt;
  logic                    is_halt;
  logic                    is_bad;

  // the word at pc is already on imem_rdata during fetch and stays there in execute
  assign imm    = {{(`CPU_XLEN-12){imem_rdata[31]}}, imem_rdata[31:20]};
  assign rs2    = imem_rdata[19:16];
  assign rs1    = imem_rdata[15:12];
  assign rd     = imem_rdata[11:8];
  assign opt    = imem_rdata[7:4];
  assign opcode = opcode_e'(imem_rdata[3:0]);

  always_comb begin
    alu_op = ALU_PASS;
    is_bad = 1'b0;
    case (opcode)
      OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_HALT: is_bad = 1'b0;
      OP_ALU: begin
        alu_op = alu_op_e'(opt);
        is_bad = (opt > ALU_XOR);
      end
      default: is_bad = 1'b1;
    endcase
  end

  assign is_halt = (opcode == OP_HALT);

  assign pc_next = branch_taken ? pc + imm[`CPU_IMEM_AW-1:0] : pc + 1'b1; // imm counts words

  // address one cycle ahead so the next instruction is ready in its fetch cycle
  always_comb begin
    case (state)
      ST_FETCH: imem_addr = pc;
      ST_EXEC:  imem_addr = pc_next;
      default:  imem_addr = '0;
    endcase
  end

  assign exec_valid = (state == ST_EXEC);
  assign busy       = (state != ST_IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      pc      <= '0;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state   <= ST_FETCH;
            pc      <= '0;
            halted  <= 1'b0;
            illegal <= 1'b0;
          end
        end
        ST_FETCH: state <= ST_EXEC;
        ST_EXEC: begin
          if (is_halt || is_bad) begin
            state   <= ST_IDLE;
            halted  <= is_halt;
            illegal <= is_bad;
          end else begin
            state <= ST_FETCH;
            pc    <= pc_next;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // downstream blocks rely on execute only happening inside a run
  assert property (@(posedge clk) disable iff (!arst_n) exec_valid |-> busy);

endmodule

`default_nettype wire

/* hdl/alu_execute.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module alu_execute (
  input  cpu_pkg::opcode_e        opcode,
  input  cpu_pkg::alu_op_e        alu_op,
  input  cpu_pkg::word_t          imm,
  input  cpu_pkg::word_t          rs1_val,
  input  cpu_pkg::word_t          rs2_val,
  output cpu_pkg::word_t          alu_result,
  output logic [`CPU_DMEM_AW-1:0] mem_index,
  output logic                    branch_taken
);
  import cpu_pkg::*;

  word_t operand_b;

  // register operand only for alu instructions, imm for the rest
  assign operand_b = (opcode == OP_ALU) ? rs2_val : imm;

  always_comb begin
    case (alu_op)
      ALU_ADD,
      ALU_PASS: alu_result = rs1_val + operand_b;
      ALU_SUB:  alu_result = rs1_val - operand_b;
      ALU_AND:  alu_result = rs1_val & operand_b;
      ALU_OR:   alu_result = rs1_val | operand_b;
      ALU_XOR:  alu_result = rs1_val ^ operand_b;
      default:  alu_result = '0;
    endcase
  end

  // lw and sw use the pass add, so the sum is the word index
  assign mem_index = alu_result[`CPU_DMEM_AW-1:0]; // wraps to dmem depth

  assign branch_taken = (opcode == OP_BEQ) && (rs1_val == rs2_val);

endmodule

`default_nettype wire

/* hdl/result_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module result_writeback (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    exec_valid,
  input  cpu_pkg::opcode_e        opcode,
  input  cpu_pkg::reg_idx_t       rd,
  input  cpu_pkg::reg_idx_t       rs1,
  input  cpu_pkg::reg_idx_t       rs2,
  input  cpu_pkg::word_t          alu_result,
  input  logic [`CPU_DMEM_AW-1:0] mem_index,
  output cpu_pkg::word_t          rs1_val,
  output cpu_pkg::word_t          rs2_val,
  output logic [`CPU_DMEM_AW-1:0] dmem_addr,
  output logic                    dmem_we,
  output cpu_pkg::word_t          dmem_wdata,
  input  cpu_pkg::word_t          dmem_rdata,
  input  cpu_pkg::reg_idx_t       host_reg_idx,
  output cpu_pkg::word_t          host_reg_val
);
  import cpu_pkg::*;

  word_t [`CPU_NREG-1:0] regs;
  word_t                 wb_data;
  logic                  reg_we;

  assign rs1_val      = regs[rs1];
  assign rs2_val      = regs[rs2];
  assign host_reg_val = regs[host_reg_idx];

  // address is live in fetch too, so load data is registered by execute
  assign dmem_addr  = mem_index;
  assign dmem_wdata = rs2_val;
  assign dmem_we    = exec_valid && (opcode == OP_SW);

  assign wb_data = (opcode == OP_LW) ? dmem_rdata : alu_result;
  assign reg_we  = exec_valid && (rd != '0) // x0 never written
                   && (opcode == OP_ADDI || opcode == OP_ALU || opcode == OP_LW);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '0;
    end else if (reg_we) begin
      regs[rd] <= wb_data;
    end
  end

  // register file only moves after an execute cycle
  assert property (@(posedge clk) disable iff (!arst_n)
    !$past(exec_valid) |-> $stable(regs));

endmodule

`default_nettype wire

/* hdl/word_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module word_mem #(
  parameter type payload_t = cpu_pkg::word_t,
  parameter int  DEPTH     = `CPU_DMEM_DEPTH
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] core_addr,
  input  logic                     core_we,
  input  payload_t                 core_wdata,
  output payload_t                 core_rdata,
  input  logic [$clog2(DEPTH)-1:0] host_addr,
  input  logic                     host_we,
  input  payload_t                 host_wdata,
  output payload_t                 host_rdata
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (core_we) begin
      mem[core_addr] <= core_wdata;
    end else if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
    core_rdata <= mem[core_addr]; // read before write
    host_rdata <= mem[host_addr];
  end

  // host writes are refused while the core runs
  assert property (@(posedge clk) !(core_we && host_we));

endmodule

`default_nettype wire

/* hdl/host_axil.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module host_axil (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [`CPU_AXI_AW-1:0]  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  cpu_pkg::word_t          wdata,
  input  logic [`CPU_XLEN/8-1:0]  wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`CPU_AXI_AW-1:0]  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output cpu_pkg::word_t          rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  input  logic                    busy,
  input  logic                    halted,
  input  logic                    illegal,
  output logic                    start,
  output logic [`CPU_IMEM_AW-1:0] imem_addr,
  output logic                    imem_we,
  output cpu_pkg::instr_t         imem_wdata,
  input  cpu_pkg::instr_t         imem_rdata,
  output logic [`CPU_DMEM_AW-1:0] dmem_addr,
  output logic                    dmem_we,
  output cpu_pkg::word_t          dmem_wdata,
  input  cpu_pkg::word_t          dmem_rdata,
  output cpu_pkg::reg_idx_t       host_reg_idx,
  input  cpu_pkg::word_t          host_reg_val
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {RG_NONE, RG_IMEM, RG_DMEM, RG_CTRL, RG_STAT, RG_REGS} region_e;

  function automatic region_e decode(input logic [`CPU_AXI_AW-1:0] addr);
    region_e rg;
    rg = RG_NONE;
    if (addr >= `CPU_IMEM_BASE && addr < `CPU_IMEM_BASE + 4 * `CPU_IMEM_DEPTH) begin
      rg = RG_IMEM;
    end else if (addr >= `CPU_DMEM_BASE && addr < `CPU_DMEM_BASE + 4 * `CPU_DMEM_DEPTH) begin
      rg = RG_DMEM;
    end else if (addr == `CPU_CTRL_ADDR) begin
      rg = RG_CTRL;
    end else if (addr == `CPU_STAT_ADDR) begin
      rg = RG_STAT;
    end else if (addr >= `CPU_REG_BASE && addr < `CPU_REG_BASE + 4 * `CPU_NREG) begin
      rg = RG_REGS;
    end
    return rg;
  endfunction

  region_e                wr_rg;
  region_e                rd_rg;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   wr_full;
  logic                   wr_part;
  logic                   wr_ok;
  logic [1:0]             wr_resp;
  logic [1:0]             rd_resp;
  word_t                  rd_word;
  logic                   rd_mem;
  logic                   rd_pend;
  logic                   rd_from_imem;
  logic [`CPU_AXI_AW-1:0] mem_byte_addr;

  assign wr_rg = decode(awaddr);
  assign rd_rg = decode(araddr);

  // aw and w taken together, one response outstanding per direction
  assign wr_fire = awvalid && wvalid && !bvalid;
  assign rd_fire = arvalid && !rvalid && !rd_pend && !wr_fire; // write wins the memory ports
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign arready = rd_fire;

  assign wr_full = (wstrb == '1);
  assign wr_part = (wstrb != '0) && !wr_full;

  always_comb begin
    case (wr_rg)
      RG_NONE:          wr_resp = `CPU_RESP_DECERR;
      RG_IMEM, RG_DMEM: wr_resp = (busy || wr_part) ? `CPU_RESP_SLVERR : `CPU_RESP_OKAY;
      RG_CTRL:          wr_resp = wr_part ? `CPU_RESP_SLVERR : `CPU_RESP_OKAY;
      default:          wr_resp = `CPU_RESP_SLVERR; // status and registers are read only
    endcase
  end

  assign wr_ok = wr_fire && wr_full && (wr_resp == `CPU_RESP_OKAY); // empty strobe writes nothing

  assign mem_byte_addr = wr_fire ? awaddr : araddr;
  assign imem_addr     = mem_byte_addr[`CPU_IMEM_AW+1:2];
  assign dmem_addr     = mem_byte_addr[`CPU_DMEM_AW+1:2];
  assign imem_we       = wr_ok && (wr_rg == RG_IMEM);
  assign dmem_we       = wr_ok && (wr_rg == RG_DMEM);
  assign imem_wdata    = wdata;
  assign dmem_wdata    = wdata;
  assign start         = wr_ok && (wr_rg == RG_CTRL) && wdata[0];
  assign host_reg_idx  = reg_idx_t'(araddr >> 2);

  always_comb begin
    rd_word = '0;
    rd_resp = `CPU_RESP_OKAY;
    case (rd_rg)
      RG_NONE: rd_resp = `CPU_RESP_DECERR;
      RG_DMEM: rd_resp = busy ? `CPU_RESP_SLVERR : `CPU_RESP_OKAY;
      RG_STAT: rd_word = word_t'({illegal, halted, busy});
      RG_REGS: rd_word = host_reg_val;
      default: rd_word = '0;
    endcase
  end

  assign rd_mem = (rd_rg == RG_IMEM) || (rd_rg == RG_DMEM && !busy); // these wait for memory

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rd_pend <= rd_mem;
        rvalid  <= !rd_mem;
      end else if (rd_pend) begin
        rd_pend <= 1'b0;
        rvalid  <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_resp;
    end
    if (rd_fire) begin
      rdata        <= rd_word;
      rresp        <= rd_resp;
      rd_from_imem <= (rd_rg == RG_IMEM);
    end else if (rd_pend) begin
      rdata <= rd_from_imem ? imem_rdata : dmem_rdata;
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

/* hdl/mini_cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module mini_cpu_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [`CPU_AXI_AW-1:0] s_axi_awaddr,
  input  logic                   s_axi_awvalid,
  output logic                   s_axi_awready,
  input  cpu_pkg::word_t         s_axi_wdata,
  input  logic [`CPU_XLEN/8-1:0] s_axi_wstrb,
  input  logic                   s_axi_wvalid,
  output logic                   s_axi_wready,
  output logic [1:0]             s_axi_bresp,
  output logic                   s_axi_bvalid,
  input  logic                   s_axi_bready,
  input  logic [`CPU_AXI_AW-1:0] s_axi_araddr,
  input  logic                   s_axi_arvalid,
  output logic                   s_axi_arready,
  output cpu_pkg::word_t         s_axi_rdata,
  output logic [1:0]             s_axi_rresp,
  output logic                   s_axi_rvalid,
  input  logic                   s_axi_rready
);
  import cpu_pkg::*;

  logic [`CPU_IMEM_AW-1:0] imem_addr, imem_host_addr;
  instr_t                  imem_rdata, imem_host_wdata, imem_host_rdata;
  logic                    imem_host_we;
  logic [`CPU_DMEM_AW-1:0] dmem_addr, dmem_host_addr, mem_index;
  word_t                   dmem_wdata, dmem_rdata, dmem_host_wdata, dmem_host_rdata;
  logic                    dmem_we, dmem_host_we;
  reg_idx_t                rd, rs1, rs2, host_reg_idx;
  word_t                   imm, rs1_val, rs2_val, alu_result, host_reg_val;
  opcode_e                 opcode;
  alu_op_e                 alu_op;
  logic                    exec_valid, branch_taken, start, busy, halted, illegal;

  fetch_decode i_fetch_decode (
    .clk, .arst_n, .start, .imem_addr, .imem_rdata, .branch_taken, .exec_valid,
    .rd, .rs1, .rs2, .imm, .opcode, .alu_op, .busy, .halted, .illegal
  );

  alu_execute i_alu_execute (
    .opcode, .alu_op, .imm, .rs1_val, .rs2_val, .alu_result, .mem_index, .branch_taken
  );

  result_writeback i_result_writeback (
    .clk, .arst_n, .exec_valid, .opcode, .rd, .rs1, .rs2, .alu_result, .mem_index,
    .rs1_val, .rs2_val, .dmem_addr, .dmem_we, .dmem_wdata, .dmem_rdata,
    .host_reg_idx, .host_reg_val
  );

  word_mem #(.payload_t(instr_t), .DEPTH(`CPU_IMEM_DEPTH)) i_imem (
    .clk,
    .core_addr(imem_addr), .core_we(1'b0), .core_wdata('0), .core_rdata(imem_rdata),
    .host_addr(imem_host_addr), .host_we(imem_host_we),
    .host_wdata(imem_host_wdata), .host_rdata(imem_host_rdata)
  );

  word_mem #(.payload_t(word_t), .DEPTH(`CPU_DMEM_DEPTH)) i_dmem (
    .clk,
    .core_addr(dmem_addr), .core_we(dmem_we), .core_wdata(dmem_wdata),
    .core_rdata(dmem_rdata),
    .host_addr(dmem_host_addr), .host_we(dmem_host_we),
    .host_wdata(dmem_host_wdata), .host_rdata(dmem_host_rdata)
  );

  host_axil i_host_axil (
    .clk, .arst_n,
    .awaddr(s_axi_awaddr), .awvalid(s_axi_awvalid), .awready(s_axi_awready),
    .wdata(s_axi_wdata), .wstrb(s_axi_wstrb), .wvalid(s_axi_wvalid), .wready(s_axi_wready),
    .bresp(s_axi_bresp), .bvalid(s_axi_bvalid), .bready(s_axi_bready),
    .araddr(s_axi_araddr), .arvalid(s_axi_arvalid), .arready(s_axi_arready),
    .rdata(s_axi_rdata), .rresp(s_axi_rresp), .rvalid(s_axi_rvalid), .rready(s_axi_rready),
    .busy, .halted, .illegal, .start,
    .imem_addr(imem_host_addr), .imem_we(imem_host_we),
    .imem_wdata(imem_host_wdata), .imem_rdata(imem_host_rdata),
    .dmem_addr(dmem_host_addr), .dmem_we(dmem_host_we),
    .dmem_wdata(dmem_host_wdata), .dmem_rdata(dmem_host_rdata),
    .host_reg_idx, .host_reg_val
  );

endmodule

`default_nettype wire

/* testbench/tb_mini_cpu.sv */
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module tb_mini_cpu;
  import cpu_pkg::*;

  localparam int DRV        = 1;     // input drive delay after the rising edge
  localparam int HS_LIMIT   = 50;    // cycles per handshake wait
  localparam int POLL_LIMIT = 10000; // status polls per run

  logic                   clk;
  logic                   arst_n;
  logic [`CPU_AXI_AW-1:0] s_axi_awaddr;
  logic                   s_axi_awvalid;
  logic                   s_axi_awready;
  word_t                  s_axi_wdata;
  logic [`CPU_XLEN/8-1:0] s_axi_wstrb;
  logic                   s_axi_wvalid;
  logic                   s_axi_wready;
  logic [1:0]             s_axi_bresp;
  logic                   s_axi_bvalid;
  logic                   s_axi_bready;
  logic [`CPU_AXI_AW-1:0] s_axi_araddr;
  logic                   s_axi_arvalid;
  logic                   s_axi_arready;
  word_t                  s_axi_rdata;
  logic [1:0]             s_axi_rresp;
  logic                   s_axi_rvalid;
  logic                   s_axi_rready;

  int     value_errors;
  int     timeouts;
  instr_t prog[$];

  mini_cpu_top i_mini_cpu_top (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic close_run();
    $display("errors: %0d value, %0d timeout", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0t: %s did not happen within the wait limit", $time, what);
    timeouts++;
    close_run();
  endtask

  task automatic check_word(input string msg, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_resp(input string msg, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAIL %0t: %s response got %b expected %b", $time, msg, got, exp);
    end
  endtask

  // imm | rs2 | rs1 | rd | opt | opcode
  function automatic instr_t encode_instr(input logic [3:0] op, input logic [3:0] opt,
                                          input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2, input int imm);
    return {12'(imm), rs2, rs1, rd, opt, op};
  endfunction

  function automatic logic [`CPU_AXI_AW-1:0] imem_byte_addr(input int idx);
    return `CPU_AXI_AW'(`CPU_IMEM_BASE + 4 * idx);
  endfunction

  function automatic logic [`CPU_AXI_AW-1:0] dmem_byte_addr(input int idx);
    return `CPU_AXI_AW'(`CPU_DMEM_BASE + 4 * idx);
  endfunction

  task automatic axi_write(input logic [`CPU_AXI_AW-1:0] addr, input word_t data,
                           input logic [3:0] strb, input logic [1:0] exp_resp);
    int cnt;
    @(posedge clk);
    #DRV;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!(s_axi_awready && s_axi_wready)) begin // aw and w are taken together
      cnt++;
      if (cnt > HS_LIMIT) abort_on_timeout("write address and data accept");
      @(negedge clk);
    end
    @(posedge clk);
    #DRV;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!s_axi_bvalid) begin
      cnt++;
      if (cnt > HS_LIMIT) abort_on_timeout("write response");
      @(negedge clk);
    end
    check_resp($sformatf("write %h", addr), s_axi_bresp, exp_resp);
    @(posedge clk);
    #DRV;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [`CPU_AXI_AW-1:0] addr, output word_t data,
                          input logic [1:0] exp_resp);
    int cnt;
    @(posedge clk);
    #DRV;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!s_axi_arready) begin
      cnt++;
      if (cnt > HS_LIMIT) abort_on_timeout("read address accept");
      @(negedge clk);
    end
    @(posedge clk);
    #DRV;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!s_axi_rvalid) begin
      cnt++;
      if (cnt > HS_LIMIT) abort_on_timeout("read data");
      @(negedge clk);
    end
    data = s_axi_rdata;
    check_resp($sformatf("read %h", addr), s_axi_rresp, exp_resp);
    @(posedge clk);
    #DRV;
    s_axi_rready = 1'b0;
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      axi_write(imem_byte_addr(i), prog[i], 4'hF, `CPU_RESP_OKAY);
    end
  endtask

  task automatic wait_idle(output word_t status);
    int polls;
    polls = 0;
    axi_read(`CPU_STAT_ADDR, status, `CPU_RESP_OKAY);
    while (status[0]) begin
      polls++;
      if (polls > POLL_LIMIT) abort_on_timeout("fall of busy");
      axi_read(`CPU_STAT_ADDR, status, `CPU_RESP_OKAY);
    end
  endtask

  task automatic run_program(output word_t status);
    axi_write(`CPU_CTRL_ADDR, 32'h1, 4'hF, `CPU_RESP_OKAY);
    wait_idle(status);
  endtask

  task automatic expect_reg(input reg_idx_t idx, input word_t exp);
    word_t val;
    axi_read(`CPU_AXI_AW'(`CPU_REG_BASE + 4 * idx), val, `CPU_RESP_OKAY);
    check_word($sformatf("x%0d", idx), val, exp);
  endtask

  task automatic addi_chain();
    word_t st;
    prog.delete();
    prog.push_back(encode_instr(OP_ADDI, 0, 1, 0, 0, 1));
    prog.push_back(encode_instr(OP_ADDI, 0, 2, 1, 0, 1)); // depends on x1
    prog.push_back(encode_instr(OP_ADDI, 0, 3, 2, 0, 2));
    prog.push_back(encode_instr(OP_HALT, 0, 0, 0, 0, 0));
    load_program();
    run_program(st);
    check_word("addi status", st, 32'h2);
    expect_reg(1, 32'd1);
    expect_reg(3, 32'd4);
  endtask

  task automatic store_then_load();
    word_t st;
    word_t val;
    prog.delete();
    prog.push_back(encode_instr(OP_ADDI, 0, 5, 0, 0, 7));
    prog.push_back(encode_instr(OP_SW, 0, 0, 0, 5, 3));
    prog.push_back(encode_instr(OP_LW, 0, 4, 0, 0, 3));
    prog.push_back(encode_instr(OP_HALT, 0, 0, 0, 0, 0));
    load_program();
    run_program(st);
    check_word("store/load status", st, 32'h2);
    axi_read(dmem_byte_addr(3), val, `CPU_RESP_OKAY);
    check_word("dmem[3]", val, 32'd7);
    expect_reg(4, 32'd7);
  endtask

  task automatic alu_operations();
    word_t st;
    word_t a;
    word_t b;
    a = $urandom();
    b = $urandom();
    axi_write(dmem_byte_addr(0), a, 4'hF, `CPU_RESP_OKAY);
    axi_write(dmem_byte_addr(1), b, 4'hF, `CPU_RESP_OKAY);
    prog.delete();
    prog.push_back(encode_instr(OP_LW, 0, 1, 0, 0, 0));
    prog.push_back(encode_instr(OP_LW, 0, 2, 0, 0, 1));
    prog.push_back(encode_instr(OP_ALU, ALU_ADD, 3, 1, 2, 0));
    prog.push_back(encode_instr(OP_ALU, ALU_SUB, 4, 1, 2, 0));
    prog.push_back(encode_instr(OP_ALU, ALU_AND, 5, 1, 2, 0));
    prog.push_back(encode_instr(OP_ALU, ALU_OR, 6, 1, 2, 0));
    prog.push_back(encode_instr(OP_ALU, ALU_XOR, 7, 1, 2, 0));
    prog.push_back(encode_instr(OP_ALU, ALU_ADD, 0, 1, 2, 0)); // x0 stays zero
    prog.push_back(encode_instr(OP_HALT, 0, 0, 0, 0, 0));
    load_program();
    run_program(st);
    check_word("alu status", st, 32'h2);
    expect_reg(3, a + b);
    expect_reg(4, a - b);
    expect_reg(5, a & b);
    expect_reg(6, a | b);
    expect_reg(7, a ^ b);
    expect_reg(0, 32'd0);
  endtask

  task automatic branch_countdown();
    word_t st;
    prog.delete();
    prog.push_back(encode_instr(OP_ADDI, 0, 1, 0, 0, 5));
    prog.push_back(encode_instr(OP_ADDI, 0, 3, 0, 0, 0));
    prog.push_back(encode_instr(OP_ADDI, 0, 1, 1, 0, -1)); // loop head
    prog.push_back(encode_instr(OP_ADDI, 0, 3, 3, 0, 1));
    prog.push_back(encode_instr(OP_BEQ, 0, 0, 1, 0, 2));   // exit to halt
    prog.push_back(encode_instr(OP_BEQ, 0, 0, 0, 0, -3));  // back to loop head
    prog.push_back(encode_instr(OP_HALT, 0, 0, 0, 0, 0));
    load_program();
    run_program(st);
    check_word("branch status", st, 32'h2);
    expect_reg(1, 32'd0);
    expect_reg(3, 32'd5);
  endtask

  task automatic host_access_rules();
    word_t st;
    word_t val;
    prog.delete();
    prog.push_back(encode_instr(OP_ADDI, 0, 1, 0, 0, 1));
    prog.push_back(encode_instr(4'hF, 0, 0, 0, 0, 0));
    load_program();
    run_program(st);
    check_word("illegal opcode status", st, 32'h4);
    prog[1] = encode_instr(OP_ALU, 4'h7, 2, 1, 1, 0); // opt beyond xor
    load_program();
    run_program(st);
    check_word("illegal alu op status", st, 32'h4);

    prog.delete();
    prog.push_back(encode_instr(OP_ADDI, 0, 1, 0, 0, 2000));
    prog.push_back(encode_instr(OP_ADDI, 0, 1, 1, 0, -1));
    prog.push_back(encode_instr(OP_BEQ, 0, 0, 1, 0, 2));
    prog.push_back(encode_instr(OP_BEQ, 0, 0, 0, 0, -2));
    prog.push_back(encode_instr(OP_HALT, 0, 0, 0, 0, 0));
    load_program();
    axi_write(`CPU_CTRL_ADDR, 32'h1, 4'hF, `CPU_RESP_OKAY);
    axi_read(`CPU_STAT_ADDR, val, `CPU_RESP_OKAY);
    check_word("status while running", val, 32'h1);
    axi_write(imem_byte_addr(1), 32'h0000_000A, 4'hF, `CPU_RESP_SLVERR);
    axi_write(dmem_byte_addr(8), 32'h1234_5678, 4'hF, `CPU_RESP_SLVERR);
    axi_read(dmem_byte_addr(8), val, `CPU_RESP_SLVERR);
    wait_idle(st);
    check_word("long loop status", st, 32'h2);
    expect_reg(1, 32'd0);
    axi_read(imem_byte_addr(1), val, `CPU_RESP_OKAY);
    check_word("imem[1] after refused write", val, prog[1]);

    axi_write(16'h4000, 32'h0, 4'hF, `CPU_RESP_DECERR);
    axi_read(16'h4000, val, `CPU_RESP_DECERR);

    axi_write(dmem_byte_addr(8), 32'h1111_1111, 4'hF, `CPU_RESP_OKAY);
    axi_write(dmem_byte_addr(8), 32'hFFFF_FFFF, 4'b0011, `CPU_RESP_SLVERR);
    axi_read(dmem_byte_addr(8), val, `CPU_RESP_OKAY);
    check_word("dmem[8] after partial strobe", val, 32'h1111_1111);
  endtask

  initial begin
    value_errors  = 0;
    timeouts      = 0;
    arst_n        = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    void'($urandom(24437));
    repeat (3) @(posedge clk);
    #DRV;
    arst_n = 1'b1;
    addi_chain();
    store_then_load();
    alu_operations();
    branch_countdown();
    host_access_rules();
    close_run();
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_decode.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/word_mem.sv
hdl/host_axil.sv
hdl/mini_cpu_top.sv
testbench/tb_mini_cpu.sv

/* Bender.yml */
package:
  name: mini_cpu

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/cpu_pkg.sv
      - hdl/fetch_decode.sv
      - hdl/alu_execute.sv
      - hdl/result_writeback.sv
      - hdl/word_mem.sv
      - hdl/host_axil.sv
      - hdl/mini_cpu_top.sv
  - target: simulation
    files:
      - testbench/tb_mini_cpu.sv
